// File: include/dfd_config.svh
`ifndef DFD_CONFIG_SVH
`define DFD_CONFIG_SVH

// **************************************************
// APB bus
// **************************************************
`define DFD_APB_ADDR_WIDTH 12
`define DFD_APB_DATA_WIDTH 32

// **************************************************
// Debug signal sources and lanes
// **************************************************
// Sixteen halfword sources feed each lane
`define DFD_NUM_HW 16
`define DFD_HW_WIDTH 16
`define DFD_NUM_LANES 4

// **************************************************
// Trace buffer and time base
// **************************************************
`define DFD_TRACE_DEPTH 16
`define DFD_TS_WIDTH 32

`endif

// File: rtl/dfdApbRegs.sv
`timescale 1ns/10ps
`include "dfd_config.svh"

module dfdApbRegs (
  input  logic                             clk,
  input  logic                             i_rstN,
  input  dfdRegPkg::regAddr_t              i_paddr,
  input  logic                             i_psel,
  input  logic                             i_penable,
  input  logic                             i_pwrite,
  input  logic [`DFD_APB_DATA_WIDTH-1:0]   i_pwdata,
  input  logic [`DFD_APB_DATA_WIDTH/8-1:0] i_pstrb,
  output logic                             o_pready,
  output logic                             o_pslverr,
  output logic [`DFD_APB_DATA_WIDTH-1:0]   o_prdata,
  output dfdTracePkg::muxSel_t             o_muxSel,
  output logic                             o_tsEnable,
  output logic                             o_tsLoad,
  output dfdTracePkg::timestamp_t          o_tsLoadValue,
  input  dfdTracePkg::timestamp_t          i_timestamp,
  output logic                             o_changeOnly,
  output logic                             o_ctrlStart,
  output logic                             o_ctrlStop,
  output logic                             o_ctrlClear,
  output dfdTracePkg::traceIdx_t           o_rdIdx,
  input  dfdTracePkg::traceRecord_t        i_rdEntry,
  input  dfdTracePkg::traceCount_t         i_count,
  input  logic                             i_full,
  input  logic                             i_active
);
  import dfdRegPkg::*;
  import dfdTracePkg::*;

  logic                           setupPhase;
  logic                           accessPhase;
  logic                           hitCtrl;
  logic                           hitMuxSel;
  logic                           hitTimestamp;
  logic                           hitStatus;
  logic                           hitBuf;
  logic                           addrErr;
  logic                           wrEn;
  logic                           changeOnlyQ;
  logic                           tsEnableQ;
  muxSel_t                        muxSelQ;
  logic [`DFD_APB_DATA_WIDTH-1:0] rdData;

  // **************************************************
  // Address decode and bus response
  // **************************************************
  assign setupPhase  = i_psel & ~i_penable;
  assign accessPhase = i_psel & i_penable;

  assign hitCtrl      = (i_paddr == REG_CTRL);
  assign hitMuxSel    = (i_paddr == REG_MUXSEL);
  assign hitTimestamp = (i_paddr == REG_TIMESTAMP);
  assign hitStatus    = (i_paddr == REG_STATUS);
  assign hitBuf       = (i_paddr >= BUF_BASE) && (i_paddr <= BUF_LAST);

  // STATUS and the buffer window are read only
  assign addrErr = ~(hitCtrl | hitMuxSel | hitTimestamp | hitStatus | hitBuf)
                 | (i_pwrite & (hitStatus | hitBuf));

  // Zero wait states, byte strobes have no effect
  assign o_pready  = accessPhase;
  assign o_pslverr = accessPhase & addrErr;
  assign wrEn      = accessPhase & i_pwrite & ~addrErr;

  // **************************************************
  // Control and select registers
  // **************************************************
  always_ff @(posedge clk) begin
    if (!i_rstN) begin
      changeOnlyQ <= 1'b0;
      tsEnableQ   <= 1'b0;
      muxSelQ     <= '0;
    end else if (wrEn) begin
      if (hitCtrl) begin
        changeOnlyQ <= i_pwdata[CTRL_CHANGE_ONLY];
        tsEnableQ   <= i_pwdata[CTRL_TS_ENABLE];
      end
      if (hitMuxSel) begin
        muxSelQ <= muxSel_t'(i_pwdata[$bits(muxSel_t)-1:0]);
      end
    end
  end

  assign o_muxSel     = muxSelQ;
  assign o_tsEnable   = tsEnableQ;
  assign o_changeOnly = changeOnlyQ;

  // Pulses land at the same edge as the write
  assign o_ctrlStart   = wrEn & hitCtrl & i_pwdata[CTRL_START];
  assign o_ctrlStop    = wrEn & hitCtrl & i_pwdata[CTRL_STOP];
  assign o_ctrlClear   = wrEn & hitCtrl & i_pwdata[CTRL_CLEAR];
  assign o_tsLoad      = wrEn & hitTimestamp;
  assign o_tsLoadValue = timestamp_t'(i_pwdata[$bits(timestamp_t)-1:0]);

  // **************************************************
  // Read path
  // **************************************************
  assign o_rdIdx = traceIdx_t'(i_paddr[BUF_IDX_MSB:BUF_IDX_LSB]);

  always_comb begin
    rdData = '0;
    if (hitCtrl) begin
      rdData[CTRL_CHANGE_ONLY] = changeOnlyQ;
      rdData[CTRL_TS_ENABLE]   = tsEnableQ;
    end else if (hitMuxSel) begin
      rdData[$bits(muxSel_t)-1:0] = muxSelQ;
    end else if (hitTimestamp) begin
      rdData[$bits(timestamp_t)-1:0] = i_timestamp;
    end else if (hitStatus) begin
      rdData[STAT_COUNT_MSB:STAT_COUNT_LSB] = i_count;
      rdData[STAT_FULL_BIT]                 = i_full;
      rdData[STAT_ACTIVE_BIT]               = i_active;
    end else if (hitBuf) begin
      case (bufWord_e'(i_paddr[BUF_WORD_MSB:BUF_WORD_LSB]))
        BUF_WORD_TS:       rdData[$bits(timestamp_t)-1:0] = i_rdEntry.ts;
        BUF_WORD_LANES_LO: rdData = i_rdEntry.bus[1:0];
        BUF_WORD_LANES_HI: rdData = i_rdEntry.bus[3:2];
        default:           rdData = '0;
      endcase
    end
  end

  // Captured in setup so it is stable through the access phase
  always_ff @(posedge clk) begin
    if (setupPhase && !i_pwrite) begin
      o_prdata <= rdData;
    end
  end

endmodule

// File: rtl/dfdDebugMux.sv
`timescale 1ns/10ps
`include "dfd_config.svh"

module dfdDebugMux (
  input  logic                  clk,
  input  logic                  i_rstN,
  input  dfdTracePkg::hwSrc_t   i_hwSrc,
  input  dfdTracePkg::muxSel_t  i_muxSel,
  output dfdTracePkg::debugBus_t o_debugBus
);
  import dfdTracePkg::*;

  debugBus_t laneNext;

  // Each lane picks its own halfword
  always_comb begin
    for (int lane = 0; lane < `DFD_NUM_LANES; lane++) begin
      laneNext[lane] = i_hwSrc[i_muxSel[lane]];
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rstN) begin
      o_debugBus <= '0;
    end else begin
      o_debugBus <= laneNext;
    end
  end

endmodule

// File: rtl/dfdRegPkg.sv
`include "dfd_config.svh"

package dfdRegPkg;

  typedef logic [`DFD_APB_ADDR_WIDTH-1:0] regAddr_t;

  // Register map
  localparam regAddr_t REG_CTRL      = 12'h000;
  localparam regAddr_t REG_MUXSEL    = 12'h004;
  localparam regAddr_t REG_TIMESTAMP = 12'h008;
  localparam regAddr_t REG_STATUS    = 12'h00C;

  // Trace buffer read window
  localparam regAddr_t BUF_BASE = 12'h100;
  localparam regAddr_t BUF_LAST = 12'h1FF;

  // Entry index and word select inside the window
  localparam int BUF_IDX_LSB  = 4;
  localparam int BUF_IDX_MSB  = 7;
  localparam int BUF_WORD_LSB = 2;
  localparam int BUF_WORD_MSB = 3;

  typedef enum logic [1:0] {
    BUF_WORD_TS       = 2'd0,
    BUF_WORD_LANES_LO = 2'd1,
    BUF_WORD_LANES_HI = 2'd2,
    BUF_WORD_RSVD     = 2'd3
  } bufWord_e;

  // Start, stop and clear are write-one pulses
  typedef enum int unsigned {
    CTRL_START       = 0,
    CTRL_STOP        = 1,
    CTRL_CLEAR       = 2,
    CTRL_CHANGE_ONLY = 3,
    CTRL_TS_ENABLE   = 4
  } ctrlBits_e;

  localparam int STAT_COUNT_LSB  = 0;
  localparam int STAT_COUNT_MSB  = 4;
  localparam int STAT_FULL_BIT   = 8;
  localparam int STAT_ACTIVE_BIT = 9;

endpackage

// File: rtl/dfdTimeSync.sv
`timescale 1ns/10ps
`include "dfd_config.svh"

module dfdTimeSync (
  input  logic                    clk,
  input  logic                    i_rstN,
  input  logic                    i_tsEnable,
  input  logic                    i_tsLoad,
  input  dfdTracePkg::timestamp_t i_tsLoadValue,
  output dfdTracePkg::timestamp_t o_timestamp
);
  import dfdTracePkg::*;

  timestamp_t tsCount;
  timestamp_t tsNext;

  // Load beats counting
  always_comb begin
    tsNext = tsCount;
    if (i_tsLoad) begin
      tsNext = i_tsLoadValue;
    end else if (i_tsEnable) begin
      tsNext = tsCount + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rstN) begin
      tsCount <= '0;
    end else begin
      tsCount <= tsNext;
    end
  end

  assign o_timestamp = tsCount;

endmodule

// File: rtl/dfdTop.sv
`timescale 1ns/10ps
`include "dfd_config.svh"

module dfdTop (
  input  logic                             clk,
  input  logic                             i_rstN,
  input  dfdRegPkg::regAddr_t              i_paddr,
  input  logic                             i_psel,
  input  logic                             i_penable,
  input  logic                             i_pwrite,
  input  logic [`DFD_APB_DATA_WIDTH-1:0]   i_pwdata,
  input  logic [`DFD_APB_DATA_WIDTH/8-1:0] i_pstrb,
  output logic                             o_pready,
  output logic                             o_pslverr,
  output logic [`DFD_APB_DATA_WIDTH-1:0]   o_prdata,
  input  dfdTracePkg::hwSrc_t              i_hwSrc,
  input  logic                             i_traceStart,
  input  logic                             i_traceStop,
  input  logic                             i_tracePulse
);

  dfdTracePkg::muxSel_t      muxSel;
  dfdTracePkg::debugBus_t    debugBus;
  dfdTracePkg::timestamp_t   timestamp;
  dfdTracePkg::timestamp_t   tsLoadValue;
  dfdTracePkg::traceIdx_t    rdIdx;
  dfdTracePkg::traceRecord_t rdEntry;
  dfdTracePkg::traceCount_t  count;
  logic                      tsEnable;
  logic                      tsLoad;
  logic                      changeOnly;
  logic                      ctrlStart;
  logic                      ctrlStop;
  logic                      ctrlClear;
  logic                      full;
  logic                      active;

  // **************************************************
  // Register block
  // **************************************************
  dfdApbRegs u_apbRegs (
    .clk           (clk),
    .i_rstN        (i_rstN),
    .i_paddr       (i_paddr),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_pwrite      (i_pwrite),
    .i_pwdata      (i_pwdata),
    .i_pstrb       (i_pstrb),
    .o_pready      (o_pready),
    .o_pslverr     (o_pslverr),
    .o_prdata      (o_prdata),
    .o_muxSel      (muxSel),
    .o_tsEnable    (tsEnable),
    .o_tsLoad      (tsLoad),
    .o_tsLoadValue (tsLoadValue),
    .i_timestamp   (timestamp),
    .o_changeOnly  (changeOnly),
    .o_ctrlStart   (ctrlStart),
    .o_ctrlStop    (ctrlStop),
    .o_ctrlClear   (ctrlClear),
    .o_rdIdx       (rdIdx),
    .i_rdEntry     (rdEntry),
    .i_count       (count),
    .i_full        (full),
    .i_active      (active)
  );

  // Selection and time base run side by side
  dfdDebugMux u_debugMux (
    .clk        (clk),
    .i_rstN     (i_rstN),
    .i_hwSrc    (i_hwSrc),
    .i_muxSel   (muxSel),
    .o_debugBus (debugBus)
  );

  dfdTimeSync u_timeSync (
    .clk           (clk),
    .i_rstN        (i_rstN),
    .i_tsEnable    (tsEnable),
    .i_tsLoad      (tsLoad),
    .i_tsLoadValue (tsLoadValue),
    .o_timestamp   (timestamp)
  );

  dfdTraceCapture u_traceCapture (
    .clk          (clk),
    .i_rstN       (i_rstN),
    .i_debugBus   (debugBus),
    .i_timestamp  (timestamp),
    .i_traceStart (i_traceStart),
    .i_traceStop  (i_traceStop),
    .i_tracePulse (i_tracePulse),
    .i_ctrlStart  (ctrlStart),
    .i_ctrlStop   (ctrlStop),
    .i_ctrlClear  (ctrlClear),
    .i_changeOnly (changeOnly),
    .i_rdIdx      (rdIdx),
    .o_rdEntry    (rdEntry),
    .o_count      (count),
    .o_full       (full),
    .o_active     (active)
  );

endmodule

// File: rtl/dfdTraceCapture.sv
`timescale 1ns/10ps
`include "dfd_config.svh"

module dfdTraceCapture (
  input  logic                      clk,
  input  logic                      i_rstN,
  input  dfdTracePkg::debugBus_t    i_debugBus,
  input  dfdTracePkg::timestamp_t   i_timestamp,
  input  logic                      i_traceStart,
  input  logic                      i_traceStop,
  input  logic                      i_tracePulse,
  input  logic                      i_ctrlStart,
  input  logic                      i_ctrlStop,
  input  logic                      i_ctrlClear,
  input  logic                      i_changeOnly,
  input  dfdTracePkg::traceIdx_t    i_rdIdx,
  output dfdTracePkg::traceRecord_t o_rdEntry,
  output dfdTracePkg::traceCount_t  o_count,
  output logic                      o_full,
  output logic                      o_active
);
  import dfdTracePkg::*;

  localparam traceCount_t DEPTH = traceCount_t'(`DFD_TRACE_DEPTH);
  localparam traceCount_t LAST  = traceCount_t'(`DFD_TRACE_DEPTH - 1);

  traceRecord_t traceMem [`DFD_TRACE_DEPTH];
  timestamp_t   tsAligned;
  logic         pulseAligned;
  debugBus_t    prevBus;
  traceCount_t  countQ;
  logic         activeQ;
  logic         fullNow;
  logic         startReq;
  logic         stopReq;
  logic         busChanged;
  logic         candidate;
  logic         wrEn;
  logic         fillWrite;

  // **************************************************
  // Alignment with the registered mux output
  // **************************************************
  always_ff @(posedge clk) begin
    tsAligned <= i_timestamp;
    prevBus   <= i_debugBus;
  end

  always_ff @(posedge clk) begin
    if (!i_rstN) begin
      pulseAligned <= 1'b0;
    end else begin
      pulseAligned <= i_tracePulse;
    end
  end

  // **************************************************
  // Arming and write decision
  // **************************************************
  assign startReq   = i_traceStart | i_ctrlStart;
  assign stopReq    = i_traceStop | i_ctrlStop;
  assign fullNow    = (countQ == DEPTH);
  assign busChanged = (i_debugBus != prevBus);

  // A pulse capture skips the change filter
  assign candidate = pulseAligned | (activeQ & (~i_changeOnly | busChanged));
  assign wrEn      = candidate & ~fullNow & ~i_ctrlClear;
  assign fillWrite = wrEn & (countQ == LAST);

  always_ff @(posedge clk) begin
    if (!i_rstN) begin
      activeQ <= 1'b0;
    end else if (i_ctrlClear) begin
      activeQ <= 1'b0;
    end else if (startReq) begin
      activeQ <= 1'b1;
    end else if (stopReq || fillWrite) begin
      activeQ <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rstN) begin
      countQ <= '0;
    end else if (i_ctrlClear) begin
      countQ <= '0;
    end else if (wrEn) begin
      countQ <= countQ + 1'b1;
    end
  end

  // **************************************************
  // Record storage, no wrap once full
  // **************************************************
  always_ff @(posedge clk) begin
    if (wrEn) begin
      traceMem[traceIdx_t'(countQ)] <= '{ts: tsAligned, bus: i_debugBus};
    end
  end

  assign o_rdEntry = traceMem[i_rdIdx];
  assign o_count   = countQ;
  assign o_full    = fullNow;
  assign o_active  = activeQ;

endmodule

// File: rtl/dfdTracePkg.sv
`include "dfd_config.svh"

package dfdTracePkg;

  // All halfword sources side by side, source 0 in the low bits
  typedef logic [`DFD_NUM_HW-1:0][`DFD_HW_WIDTH-1:0] hwSrc_t;

  typedef logic [$clog2(`DFD_NUM_HW)-1:0] laneSel_t;

  typedef laneSel_t [`DFD_NUM_LANES-1:0] muxSel_t;

  typedef logic [`DFD_NUM_LANES-1:0][`DFD_HW_WIDTH-1:0] debugBus_t;

  typedef logic [`DFD_TS_WIDTH-1:0] timestamp_t;

  // One captured trace entry
  typedef struct packed {
    timestamp_t ts;
    debugBus_t  bus;
  } traceRecord_t;

  typedef logic [$clog2(`DFD_TRACE_DEPTH)-1:0] traceIdx_t;

  // Needs one extra bit to hold a full count
  typedef logic [$clog2(`DFD_TRACE_DEPTH):0] traceCount_t;

endpackage

// File: sim.f
+incdir+include
rtl/dfdRegPkg.sv
rtl/dfdTracePkg.sv
rtl/dfdApbRegs.sv
rtl/dfdDebugMux.sv
rtl/dfdTimeSync.sv
rtl/dfdTraceCapture.sv
rtl/dfdTop.sv
verification/dfdTopTb.sv

// File: verification/dfdTopTb.sv
`timescale 1ns/10ps
`include "dfd_config.svh"

module dfdTopTb;
  import dfdRegPkg::*;
  import dfdTracePkg::*;

  localparam int TIMEOUT_CYCLES = 3000;
  localparam int CAP_LEN  = 12;
  localparam int CHG_LEN  = 10;
  localparam int FULL_LEN = 20;
  localparam logic [31:0] CTRL_TS_ON     = 32'h1 << CTRL_TS_ENABLE;
  localparam logic [31:0] CTRL_CLEAR_BIT = 32'h1 << CTRL_CLEAR;
  localparam logic [31:0] CTRL_CHG_ON    = 32'h1 << CTRL_CHANGE_ONLY;
  localparam timestamp_t  LOAD_VAL       = 32'h1234_0000;
  // Lanes 0..3 pick sources 3, 0, 15 and 7
  localparam muxSel_t     LANE_SEL       = 16'h7F03;

  logic                             clk;
  logic                             i_rstN;
  regAddr_t                         i_paddr;
  logic                             i_psel;
  logic                             i_penable;
  logic                             i_pwrite;
  logic [`DFD_APB_DATA_WIDTH-1:0]   i_pwdata;
  logic [`DFD_APB_DATA_WIDTH/8-1:0] i_pstrb;
  logic                             o_pready;
  logic                             o_pslverr;
  logic [`DFD_APB_DATA_WIDTH-1:0]   o_prdata;
  hwSrc_t                           i_hwSrc;
  logic                             i_traceStart;
  logic                             i_traceStop;
  logic                             i_tracePulse;

  int     cycles = 0;
  int     setupCycle;
  int     passCount;
  int     failCount;
  integer seed;

  dfdTop u_dut (
    .clk          (clk),
    .i_rstN       (i_rstN),
    .i_paddr      (i_paddr),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_pwdata     (i_pwdata),
    .i_pstrb      (i_pstrb),
    .o_pready     (o_pready),
    .o_pslverr    (o_pslverr),
    .o_prdata     (o_prdata),
    .i_hwSrc      (i_hwSrc),
    .i_traceStart (i_traceStart),
    .i_traceStop  (i_traceStop),
    .i_tracePulse (i_tracePulse)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // **************************************************
  // Compare tasks
  // **************************************************
  task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
      failCount++;
    end else begin
      passCount++;
    end
  endtask

  task automatic checkBus(input string name, input debugBus_t exp, input debugBus_t act);
    if (exp !== act) begin
      $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
      failCount++;
    end else begin
      passCount++;
    end
  endtask

  task automatic checkStamp(input string name, input timestamp_t exp, input timestamp_t act);
    if (exp !== act) begin
      $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
      failCount++;
    end else begin
      passCount++;
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
      failCount++;
    end else begin
      passCount++;
    end
  endtask

  // **************************************************
  // Stimulus helpers
  // **************************************************
  task automatic waitCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic apbWrite(input regAddr_t addr, input logic [31:0] data, output logic err);
    i_paddr   = addr;
    i_pwrite  = 1'b1;
    i_pwdata  = data;
    i_psel    = 1'b1;
    i_penable = 1'b0;
    waitCycles(1);
    i_penable = 1'b1;
    #2;
    err = o_pslverr;
    checkFlag("o_pready", 1'b1, o_pready);
    waitCycles(1);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic apbRead(input regAddr_t addr, output logic [31:0] data, output logic err);
    setupCycle = cycles;
    i_paddr   = addr;
    i_pwrite  = 1'b0;
    i_psel    = 1'b1;
    i_penable = 1'b0;
    waitCycles(1);
    i_penable = 1'b1;
    #2;
    data = o_prdata;
    err  = o_pslverr;
    checkFlag("o_pready", 1'b1, o_pready);
    waitCycles(1);
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic makePattern(output hwSrc_t pat);
    logic [$bits(hwSrc_t)-1:0] flat;
    int w;
    for (w = 0; w < $bits(hwSrc_t) / 32; w++) begin
      flat[w*32 +: 32] = $random(seed);
    end
    pat = flat;
  endtask

  // Lane n carries the halfword whose number sits in select field n
  function automatic debugBus_t pickLanes(input hwSrc_t src, input muxSel_t sel);
    logic [$bits(hwSrc_t)-1:0]    flatSrc;
    logic [$bits(debugBus_t)-1:0] flatBus;
    int lane;
    flatSrc = src;
    for (lane = 0; lane < `DFD_NUM_LANES; lane++) begin
      flatBus[lane*`DFD_HW_WIDTH +: `DFD_HW_WIDTH] =
        flatSrc[sel[lane]*`DFD_HW_WIDTH +: `DFD_HW_WIDTH];
    end
    return flatBus;
  endfunction

  task automatic readEntry(input traceIdx_t idx, output traceRecord_t rec);
    regAddr_t    base;
    logic [31:0] word;
    logic        err;
    base = BUF_BASE | regAddr_t'({idx, 4'h0});
    apbRead(base, word, err);
    rec.ts = word;
    apbRead(base | 12'h4, word, err);
    rec.bus[1:0] = word;
    apbRead(base | 12'h8, word, err);
    rec.bus[3:2] = word;
    checkFlag("o_pslverr", 1'b0, err);
  endtask

  task automatic checkStatus(input int expCount, input logic expFull, input logic expActive);
    logic [31:0] st;
    logic        err;
    apbRead(REG_STATUS, st, err);
    checkWord("STATUS.count", 32'(expCount), 32'(st[STAT_COUNT_MSB:STAT_COUNT_LSB]));
    checkFlag("STATUS.full", expFull, st[STAT_FULL_BIT]);
    checkFlag("STATUS.active", expActive, st[STAT_ACTIVE_BIT]);
  endtask

  task automatic reportTest(input string name, input int errBefore);
    if (failCount == errBefore) begin
      $display("Test %s passed", name);
    end else begin
      $display("Test %s failed with %0d errors", name, failCount - errBefore);
    end
  endtask

  // **************************************************
  // Directed tests
  // **************************************************
  task automatic testRegisterAccess;
    logic [31:0] data;
    logic        err;
    int          errBefore;
    errBefore = failCount;
    checkFlag("o_pready idle", 1'b0, o_pready);
    checkFlag("o_pslverr idle", 1'b0, o_pslverr);
    checkStatus(0, 1'b0, 1'b0);
    apbWrite(REG_MUXSEL, 32'h0000_A5C3, err);
    checkFlag("o_pslverr", 1'b0, err);
    apbRead(REG_MUXSEL, data, err);
    checkWord("MUXSEL", 32'h0000_A5C3, data);
    // Pulse bits read back as zero
    apbWrite(REG_CTRL, 32'h0000_001F, err);
    apbRead(REG_CTRL, data, err);
    checkWord("CTRL", 32'h0000_0018, data);
    apbWrite(REG_CTRL, 32'h0, err);
    apbRead(REG_CTRL, data, err);
    checkWord("CTRL", 32'h0, data);
    apbRead(12'h010, data, err);
    checkFlag("o_pslverr unmapped", 1'b1, err);
    apbWrite(REG_STATUS, 32'hFFFF_FFFF, err);
    checkFlag("o_pslverr STATUS write", 1'b1, err);
    apbWrite(BUF_BASE | 12'h020, 32'h1, err);
    checkFlag("o_pslverr buffer write", 1'b1, err);
    reportTest("register access", errBefore);
  endtask

  task automatic testTimestamp;
    logic [31:0] t1;
    logic [31:0] t2;
    logic        err;
    int          c1;
    int          errBefore;
    errBefore = failCount;
    apbWrite(REG_CTRL, CTRL_TS_ON, err);
    apbWrite(REG_TIMESTAMP, LOAD_VAL, err);
    apbRead(REG_TIMESTAMP, t1, err);
    c1 = setupCycle;
    checkStamp("TIMESTAMP", LOAD_VAL, t1);
    waitCycles(5);
    apbRead(REG_TIMESTAMP, t2, err);
    checkStamp("TIMESTAMP delta", timestamp_t'(setupCycle - c1), t2 - t1);
    // Counter frozen
    apbWrite(REG_CTRL, 32'h0, err);
    apbRead(REG_TIMESTAMP, t1, err);
    waitCycles(6);
    apbRead(REG_TIMESTAMP, t2, err);
    checkStamp("TIMESTAMP held", t1, t2);
    reportTest("timestamp", errBefore);
  endtask

  task automatic testCaptureAll;
    hwSrc_t       pat [CAP_LEN];
    traceRecord_t rec;
    logic         err;
    int           i;
    int           errBefore;
    errBefore = failCount;
    apbWrite(REG_MUXSEL, 32'(LANE_SEL), err);
    apbWrite(REG_CTRL, CTRL_CLEAR_BIT | CTRL_TS_ON, err);
    for (i = 0; i < CAP_LEN; i++) begin
      makePattern(pat[i]);
    end
    // Counter holds LOAD_VAL in the cycle that presents the first pattern
    apbWrite(REG_TIMESTAMP, LOAD_VAL, err);
    for (i = 0; i < CAP_LEN; i++) begin
      i_hwSrc      = pat[i];
      i_traceStart = (i == 0);
      waitCycles(1);
    end
    i_traceStart = 1'b0;
    i_traceStop  = 1'b1;
    waitCycles(1);
    i_traceStop  = 1'b0;
    checkStatus(CAP_LEN, 1'b0, 1'b0);
    for (i = 0; i < CAP_LEN; i++) begin
      readEntry(traceIdx_t'(i), rec);
      checkBus($sformatf("entry %0d bus", i), pickLanes(pat[i], LANE_SEL), rec.bus);
      checkStamp($sformatf("entry %0d ts", i), LOAD_VAL + timestamp_t'(i), rec.ts);
    end
    reportTest("capture every cycle", errBefore);
  endtask

  task automatic testChangeFilter;
    hwSrc_t       pat [CHG_LEN];
    hwSrc_t       pre;
    debugBus_t    expQ [$];
    debugBus_t    prevExp;
    debugBus_t    cur;
    traceRecord_t rec;
    logic         err;
    int           i;
    int           errBefore;
    errBefore = failCount;
    makePattern(pre);
    for (i = 0; i < CHG_LEN; i++) begin
      if (i == 2 || i == 3 || i == 6) begin
        pat[i] = pat[i-1];
      end else if (i == 8) begin
        // Source 1 feeds no lane, so the bus stays the same
        pat[i]    = pat[i-1];
        pat[i][1] = ~pat[i-1][1];
      end else begin
        makePattern(pat[i]);
      end
    end
    prevExp = pickLanes(pre, LANE_SEL);
    for (i = 0; i < CHG_LEN; i++) begin
      cur = pickLanes(pat[i], LANE_SEL);
      if (cur != prevExp) begin
        expQ.push_back(cur);
      end
      prevExp = cur;
    end
    apbWrite(REG_MUXSEL, 32'(LANE_SEL), err);
    i_hwSrc = pre;
    apbWrite(REG_CTRL, CTRL_CLEAR_BIT | CTRL_CHG_ON | CTRL_TS_ON, err);
    for (i = 0; i < CHG_LEN; i++) begin
      i_hwSrc      = pat[i];
      i_traceStart = (i == 0);
      waitCycles(1);
    end
    i_traceStart = 1'b0;
    i_traceStop  = 1'b1;
    waitCycles(1);
    i_traceStop  = 1'b0;
    checkStatus(expQ.size(), 1'b0, 1'b0);
    for (i = 0; i < expQ.size(); i++) begin
      readEntry(traceIdx_t'(i), rec);
      checkBus($sformatf("entry %0d bus", i), expQ[i], rec.bus);
    end
    reportTest("change-only filter", errBefore);
  endtask

  task automatic testFullClearPulse;
    hwSrc_t       pat [FULL_LEN];
    hwSrc_t       pulsePat;
    traceRecord_t rec;
    logic         err;
    int           i;
    int           errBefore;
    errBefore = failCount;
    apbWrite(REG_MUXSEL, 32'(LANE_SEL), err);
    apbWrite(REG_CTRL, CTRL_CLEAR_BIT | CTRL_TS_ON, err);
    for (i = 0; i < FULL_LEN; i++) begin
      makePattern(pat[i]);
      i_hwSrc      = pat[i];
      i_traceStart = (i == 0);
      waitCycles(1);
    end
    i_traceStart = 1'b0;
    checkStatus(`DFD_TRACE_DEPTH, 1'b1, 1'b0);
    readEntry(traceIdx_t'(`DFD_TRACE_DEPTH - 1), rec);
    checkBus("entry 15 bus", pickLanes(pat[`DFD_TRACE_DEPTH - 1], LANE_SEL), rec.bus);
    apbWrite(REG_CTRL, CTRL_CLEAR_BIT | CTRL_TS_ON, err);
    checkStatus(0, 1'b0, 1'b0);
    // Single-shot capture while idle
    makePattern(pulsePat);
    i_hwSrc      = pulsePat;
    i_tracePulse = 1'b1;
    waitCycles(1);
    i_tracePulse = 1'b0;
    makePattern(i_hwSrc);
    waitCycles(3);
    checkStatus(1, 1'b0, 1'b0);
    readEntry(traceIdx_t'(0), rec);
    checkBus("pulse entry bus", pickLanes(pulsePat, LANE_SEL), rec.bus);
    reportTest("full, clear and pulse", errBefore);
  endtask

  initial begin
    clk          = 1'b0;
    i_rstN       = 1'b0;
    i_paddr      = '0;
    i_psel       = 1'b0;
    i_penable    = 1'b0;
    i_pwrite     = 1'b0;
    i_pwdata     = '0;
    i_pstrb      = '1;
    i_hwSrc      = '0;
    i_traceStart = 1'b0;
    i_traceStop  = 1'b0;
    i_tracePulse = 1'b0;
    seed         = 32'hc397;
    passCount    = 0;
    failCount    = 0;
    repeat (4) @(posedge clk);
    #1;
    i_rstN = 1'b1;
    testRegisterAccess();
    testTimestamp();
    testCaptureAll();
    testChangeFilter();
    testFullClearPulse();
    $display("Checks passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
